// File: dv/dramModel.sv
/*
 * DRAM slot memory with random read delay and back-pressure
 */
`default_nettype none

module dramModel (
	input wire Clock,
	input wire rstN,
	// Stall pattern from the testbench top
	input wire cmdStall,
	input wire wrStall,
	input wire [1:0] readDelay,
	input wire oramPkg::dramCmdT DRAMCommand,
	input wire DRAMCommandValid,
	output logic DRAMCommandReady,
	output oramPkg::dramWordT DRAMReadData,
	output logic DRAMReadDataValid,
	input wire DRAMReadDataReady,
	input wire oramPkg::dramWordT DRAMWriteData,
	input wire DRAMWriteDataValid,
	output logic DRAMWriteDataReady
);

	oramPkg::dramWordT mem [32];
	oramPkg::ddrAddrT rdAddrQ[$];
	int rdDueQ[$];
	oramPkg::ddrAddrT wrAddrQ[$];
	oramPkg::dramWordT wrWordQ[$];
	int cycle;

	// Fill pattern covers every address bit
	initial begin
		for (int a = 0; a < 32; a++) begin
			mem[a] = {8'(a * 37), 42'(a) * 42'h10203_0405};
		end
		cycle = 0;
		DRAMCommandReady = 1'b0;
		DRAMWriteDataReady = 1'b0;
		DRAMReadDataValid = 1'b0;
		DRAMReadData = '0;
	end

	// --------------------
	// Transfers seen on the rising edge
	always @(posedge Clock) begin
		cycle <= cycle + 1;
		if (rstN) begin
			if (DRAMCommandValid && DRAMCommandReady) begin
				if (DRAMCommand.write) begin
					wrAddrQ.push_back(DRAMCommand.addr);
				end else begin
					rdAddrQ.push_back(DRAMCommand.addr);
					rdDueQ.push_back(cycle + int'(readDelay) + 1);
				end
			end
			if (DRAMReadDataValid && DRAMReadDataReady) begin
				void'(rdAddrQ.pop_front());
				void'(rdDueQ.pop_front());
			end
			if (DRAMWriteDataValid && DRAMWriteDataReady) wrWordQ.push_back(DRAMWriteData);
			// Command and data may arrive in either order
			while (wrAddrQ.size() > 0 && wrWordQ.size() > 0) begin
				mem[wrAddrQ.pop_front()] = wrWordQ.pop_front();
			end
		end
	end

	// Outputs change on the falling edge only
	always @(negedge Clock) begin
		DRAMCommandReady <= rstN && !cmdStall;
		DRAMWriteDataReady <= rstN && !wrStall;
		// Reads wait for writes whose data is still on its way
		if (rdAddrQ.size() > 0 && wrAddrQ.size() == 0 && cycle >= rdDueQ[0]) begin
			DRAMReadDataValid <= 1'b1;
			DRAMReadData <= mem[rdAddrQ[0]];
		end else begin
			DRAMReadDataValid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: dv/tbClock.sv
/*
 * Testbench clock and reset
 */
`default_nettype none

module tbClock (
	output logic Clock,
	output logic rstN
);

	initial Clock = 1'b0;
	always #5 Clock = !Clock;

	// Reset held for 5 cycles, released on a falling edge
	initial begin
		rstN = 1'b0;
		repeat (5) @(posedge Clock);
		@(negedge Clock);
		rstN = 1'b1;
	end

endmodule

`default_nettype wire

// File: dv/tbPathOram.sv
/*
 * Path ORAM backend testbench: LFSR stimulus, reference model,
 * load, path address and DRAM cipher checks, watchdog
 */
`default_nettype none

module tbPathOram;

	localparam logic [31:0] CipherKey = 32'h5a17c3e9;
	localparam int NumRandom = 200;
	localparam int NumCmds = NumRandom + 3;
	localparam int NumBlocks = 12;

	logic Clock, rstN;
	oramPkg::bkReqT Command;
	logic CommandValid, CommandReady;
	logic [31:0] LoadData, StoreData;
	logic LoadValid, LoadReady, StoreValid, StoreReady;
	oramPkg::dramCmdT DRAMCommand;
	logic DRAMCommandValid, DRAMCommandReady;
	oramPkg::dramWordT DRAMReadData, DRAMWriteData;
	logic DRAMReadDataValid, DRAMReadDataReady, DRAMWriteDataValid, DRAMWriteDataReady;
	logic cmdStall, wrStall;
	logic [1:0] readDelay;

	logic [31:0] lfsr = 32'hb1f21cea;
	logic [31:0] refMem [64];
	logic [63:0] refWritten;
	logic [2:0] posMap [64];
	logic [31:0] expLoad;
	logic [2:0] curLeaf;
	logic initSeen;
	logic [7:0] seedExp;
	logic [5:0] cmdLog[$];
	logic [4:0] wrAddrQ[$];
	oramPkg::dramWordT wrWordQ[$];
	int loadErrors, pathErrors, dramErrors, protoErrors;

	tbClock clockGen (.Clock(Clock), .rstN(rstN));

	pathOramBackend #(.CipherKey(CipherKey)) DUT (.*);

	dramModel dram (.*);

	// --------------------
	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Reference: last stored data, zero if never written
	function automatic logic [31:0] expectedLoad(input logic [5:0] a);
		return refWritten[a] ? refMem[a] : 32'h0;
	endfunction

	function automatic logic [41:0] rotl42(input logic [41:0] v, input int n);
		return (v << n) | (v >> (42 - n));
	endfunction

	// Pad from key, slot address and seed, two mixing rounds
	function automatic logic [41:0] expectedPad(input logic [4:0] a, input logic [7:0] s);
		logic [41:0] k;
		logic [41:0] v;
		k = {CipherKey[9:0], CipherKey};
		v = {a[2:0], s, a, s, a, s, a} ^ k;
		v = rotl42(v, 7) ^ k;
		v = v + rotl42(k, 21);
		v = rotl42(v, 13) ^ k;
		v = v + rotl42(k, 21);
		return v;
	endfunction

	function automatic logic [4:0] pathAddr(input logic [2:0] leaf, input int lv, input int s);
		return 5'((((1 << lv) - 1) + (leaf >> (3 - lv))) * 2 + s);
	endfunction

	// Decrypt one write word and check its seed and contents
	task automatic checkWriteWord(input logic [4:0] a, input oramPkg::dramWordT w);
		logic [41:0] pad;
		oramPkg::slotT plain;
		int lv;
		pad = expectedPad(a, w.seed);
		plain = w.cipher ^ pad;
		lv = 0;
		while (((2 << lv) - 1) <= a / 2) lv++;
		assert (w.seed == seedExp) else begin
			dramErrors++;
			$display("Fail at %0t: seed %0d, expected %0d", $time, w.seed, seedExp);
		end
		seedExp = seedExp + 8'd1;
		if (!initSeen) begin
			assert (plain == '0) else begin
				dramErrors++;
				$display("Fail at %0t: init slot %0d decrypts to %h", $time, a, plain);
			end
		end else if (plain.valid) begin
			assert ((plain.leaf >> (3 - lv)) == (curLeaf >> (3 - lv))) else begin
				dramErrors++;
				$display("Fail at %0t: leaf %0d evicted to level %0d of path %0d",
					$time, plain.leaf, lv, curLeaf);
			end
			// Decrypted block must match the reference data and position
			assert (plain.data == expectedLoad(plain.pAddr)
					&& plain.leaf == posMap[plain.pAddr]) else begin
				dramErrors++;
				$display("Fail at %0t: block %0d written with data %h leaf %0d",
					$time, plain.pAddr, plain.data, plain.leaf);
			end
		end else begin
			assert (plain == '0) else begin
				dramErrors++;
				$display("Fail at %0t: empty slot %0d decrypts to %h", $time, a, plain);
			end
		end
	endtask

	// DRAM traffic monitor
	always @(posedge Clock) begin
		if (rstN) begin
			if (DRAMCommandValid && DRAMCommandReady) begin
				cmdLog.push_back({DRAMCommand.write, DRAMCommand.addr});
				if (DRAMCommand.write) wrAddrQ.push_back(DRAMCommand.addr);
			end
			if (DRAMReadDataValid) begin
				assert (DRAMReadDataReady) else begin
					protoErrors++;
					$display("Fail at %0t: read data not accepted by the backend", $time);
				end
			end
			if (DRAMWriteDataValid && DRAMWriteDataReady) wrWordQ.push_back(DRAMWriteData);
			while (wrAddrQ.size() > 0 && wrWordQ.size() > 0) begin
				checkWriteWord(wrAddrQ.pop_front(), wrWordQ.pop_front());
			end
		end
	end

	// Load compare
	always @(posedge Clock) begin
		if (rstN && LoadValid && LoadReady) begin
			assert (LoadData == expLoad) else begin
				loadErrors++;
				$display("Fail at %0t: load %h, expected %h", $time, LoadData, expLoad);
			end
		end
	end

	// Random stalls and load back-pressure
	always @(negedge Clock) begin
		logic [31:0] r;
		r = randBits(5);
		cmdStall <= r[0] && r[1];
		wrStall <= r[2] && r[3];
		LoadReady <= r[4];
		r = randBits(2);
		readDelay <= r[1:0];
	end

	// Read list root first, write list leaf first
	task automatic checkPath(input logic [2:0] leaf);
		logic [5:0] exp;
		assert (cmdLog.size() == 16) else begin
			pathErrors++;
			$display("Fail at %0t: access on leaf %0d issued %0d DRAM commands",
				$time, leaf, cmdLog.size());
		end
		for (int i = 0; i < 16 && i < cmdLog.size(); i++) begin
			if (i < 8) exp = {1'b0, pathAddr(leaf, i / 2, i % 2)};
			else exp = {1'b1, pathAddr(leaf, 3 - (i - 8) / 2, i % 2)};
			assert (cmdLog[i] == exp) else begin
				pathErrors++;
				$display("Fail at %0t: command %0d is %h, expected %h", $time, i, cmdLog[i], exp);
			end
		end
		cmdLog.delete();
	endtask

	task automatic access(input logic write, input logic [5:0] a, input logic [31:0] d,
			input logic [2:0] newLeaf);
		curLeaf = posMap[a];
		expLoad = expectedLoad(a);
		@(negedge Clock);
		Command = '{cmd: write ? oramPkg::CmdWrite : oramPkg::CmdRead, pAddr: a,
			currentLeaf: curLeaf, remappedLeaf: newLeaf};
		CommandValid = 1'b1;
		do @(posedge Clock); while (!(CommandValid && CommandReady));
		@(negedge Clock);
		CommandValid = 1'b0;
		if (write) begin
			StoreData = d;
			StoreValid = 1'b1;
			do @(posedge Clock); while (!(StoreValid && StoreReady));
			@(negedge Clock);
			StoreValid = 1'b0;
			refMem[a] = d;
			refWritten[a] = 1'b1;
		end else begin
			do @(posedge Clock); while (!(LoadValid && LoadReady));
		end
		posMap[a] = newLeaf;
		do @(posedge Clock); while (!CommandReady);
		checkPath(curLeaf);
	endtask

	// --------------------
	// Stimulus
	initial begin
		logic [31:0] r, d, leafR, data;
		Command = '0;
		CommandValid = 1'b0;
		StoreData = '0;
		StoreValid = 1'b0;
		LoadReady = 1'b0;
		cmdStall = 1'b0;
		wrStall = 1'b0;
		readDelay = '0;
		refWritten = '0;
		initSeen = 1'b0;
		seedExp = '0;
		loadErrors = 0;
		pathErrors = 0;
		dramErrors = 0;
		protoErrors = 0;
		for (int i = 0; i < 64; i++) posMap[i] = 3'(i);
		// Handshake outputs stay low while reset is held
		@(negedge Clock);
		assert (!CommandReady && !LoadValid && !StoreReady && !DRAMCommandValid
				&& !DRAMWriteDataValid) else begin
			protoErrors++;
			$display("Fail at %0t: handshake outputs high during reset", $time);
		end
		do @(posedge Clock); while (!(rstN && CommandReady));
		initSeen = 1'b1;
		assert (cmdLog.size() == 30) else begin
			pathErrors++;
			$display("Fail at %0t: init issued %0d DRAM commands instead of 30",
				$time, cmdLog.size());
		end
		for (int i = 0; i < 30 && i < cmdLog.size(); i++) begin
			assert (cmdLog[i] == {1'b1, 5'(i)}) else begin
				pathErrors++;
				$display("Fail at %0t: init command %0d is %h", $time, i, cmdLog[i]);
			end
		end
		cmdLog.delete();
		// Unwritten read, then write and read back on a new leaf
		access(1'b0, 6'd3, 32'h0, 3'd5);
		access(1'b1, 6'd8, 32'hcafe_0123, 3'd2);
		access(1'b0, 6'd8, 32'h0, 3'd6);
		for (int n = 0; n < NumRandom; n++) begin
			r = randBits(1);
			d = randBits(4);
			d = (d % NumBlocks) * 5 + 3;
			leafR = randBits(3);
			data = randBits(32);
			access(r[0], 6'(d), data, 3'(leafR));
		end
		$display("Errors: %0d load, %0d path, %0d DRAM, %0d handshake",
			loadErrors, pathErrors, dramErrors, protoErrors);
		if (loadErrors + pathErrors + dramErrors + protoErrors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// Watchdog, 300 cycles per command plus init
	initial begin
		#((NumCmds + 2) * 300 * 10);
		$display("Timeout: the backend stopped making progress");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the Path ORAM backend testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
	--top-module tbPathOram -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "Failures found, see sim.log"
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
	echo "No pass line in sim.log"
	exit 1
fi
exit 0

// File: tb.f
verilog/oramPkg.sv
verilog/slotCipher.sv
verilog/stash.sv
verilog/pathAddrGen.sv
verilog/backendControl.sv
verilog/pathOramBackend.sv
dv/tbClock.sv
dv/dramModel.sv
dv/tbPathOram.sv

// File: verilog/backendControl.sv
/*
 * Access FSM: tree init, path read, serve, path write-back
 */
`default_nettype none

module backendControl #(
	parameter int ORAML = oramPkg::ORAML
) (
	input wire Clock,
	input wire rstN,

	// Frontend
	input wire oramPkg::bkReqT Command,
	input wire CommandValid,
	output logic CommandReady,
	input wire StoreValid,
	output logic StoreReady,
	input wire LoadReady,
	output logic LoadValid,

	// Address generator
	output logic pathStart,
	output logic [ORAML-1:0] pathLeaf,
	output logic pathWrite,
	input wire pathDone,

	// Stash
	input wire absorbDone,
	input wire evictDone,
	output logic serveGo,
	output logic remapGo,
	output logic storeFire,
	output logic [ORAML-1:0] evictLeaf,
	output oramPkg::bkReqT request,
	output logic initDone
);

	typedef enum logic [2:0] {Init, Idle, ReadPath, Serve, WritePath} stateT;

	stateT state;
	oramPkg::bkReqT req;
	logic serveArmed;
	// Write phases end on two independent pulses
	logic cmdsSeen;
	logic dataSeen;
	logic accept;
	logic serveFire;
	logic writeDone;

	assign CommandReady = state == Idle;
	assign accept = CommandValid && CommandReady;

	// Stash looks up the block in the first Serve cycle, data is ready one later
	assign serveGo = state == Serve && !serveArmed;
	assign LoadValid = state == Serve && serveArmed && req.cmd == oramPkg::CmdRead;
	assign StoreReady = state == Serve && serveArmed && req.cmd == oramPkg::CmdWrite;
	assign storeFire = StoreValid && StoreReady;
	assign serveFire = (LoadValid && LoadReady) || storeFire;
	assign remapGo = serveFire;

	// Init and write-back both write
	assign pathWrite = state != ReadPath;
	assign pathLeaf = req.currentLeaf;
	assign evictLeaf = req.currentLeaf;
	assign request = req;
	assign writeDone = (cmdsSeen || pathDone) && (dataSeen || evictDone);

	// --------------------
	// Init walk starts straight out of reset
	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			state <= Init;
			pathStart <= 1'b1;
			initDone <= 1'b0;
			serveArmed <= 1'b0;
			cmdsSeen <= 1'b0;
			dataSeen <= 1'b0;
		end else begin
			pathStart <= 1'b0;
			case (state)
				Init, WritePath: begin
					if (writeDone) begin
						state <= Idle;
						initDone <= 1'b1;
						cmdsSeen <= 1'b0;
						dataSeen <= 1'b0;
					end else begin
						if (pathDone) cmdsSeen <= 1'b1;
						if (evictDone) dataSeen <= 1'b1;
					end
				end
				Idle: begin
					if (accept) begin
						state <= ReadPath;
						pathStart <= 1'b1;
					end
				end
				ReadPath: begin
					// Whole path is in the stash
					if (absorbDone) state <= Serve;
				end
				Serve: begin
					serveArmed <= !serveFire;
					if (serveFire) begin
						state <= WritePath;
						pathStart <= 1'b1;
					end
				end
				default: state <= Init;
			endcase
		end
	end

	// Latched frontend command
	always_ff @(posedge Clock) begin
		if (accept) req <= Command;
	end

	// Frontend opens only after every path phase has wound down
	assert property (@(posedge Clock) disable iff (!rstN)
		CommandReady |-> !pathDone && !absorbDone && !evictDone);

endmodule

`default_nettype wire

// File: verilog/oramPkg.sv
/*
 * Tree constants, command codes and slot structs of the Path ORAM backend
 * Heap-order slot address helper
 */
`default_nettype none

package oramPkg;

	// --------------------
	// Tree defaults, the top level passes its own values down
	localparam int ORAML = 3;
	localparam int ORAMZ = 2;
	localparam int ORAMU = 6;
	localparam int FEDWidth = 32;
	localparam int ORAMC = 12;
	// Enough for 15 buckets of 2 slots
	localparam int DDRAWidth = 5;
	localparam int SeedWidth = 8;

	typedef logic [DDRAWidth-1:0] ddrAddrT;

	typedef enum logic {CmdRead, CmdWrite} bkCmd;

	// --------------------
	// Plaintext bucket slot, 42 bits
	typedef struct packed {
		logic valid;
		logic [ORAMU-1:0] pAddr;
		logic [ORAML-1:0] leaf;
		logic [FEDWidth-1:0] data;
	} slotT;

	// Seed travels in clear next to the ciphertext
	typedef struct packed {
		logic [SeedWidth-1:0] seed;
		logic [$bits(slotT)-1:0] cipher;
	} dramWordT;

	typedef struct packed {
		bkCmd cmd;
		logic [ORAMU-1:0] pAddr;
		logic [ORAML-1:0] currentLeaf;
		logic [ORAML-1:0] remappedLeaf;
	} bkReqT;

	typedef struct packed {
		logic write;
		ddrAddrT addr;
	} dramCmdT;

	// Slot address on the path to leaf, root is level 0
	// Bucket on level d comes from the top d leaf bits
	function automatic int unsigned pathSlotAddr(input int unsigned leaf,
			input int unsigned level, input int unsigned slot,
			input int unsigned levels, input int unsigned z);
		int unsigned bucket;
		bucket = (1 << level) - 1 + (leaf >> (levels - level));
		return bucket * z + slot;
	endfunction

endpackage

`default_nettype wire

// File: verilog/pathAddrGen.sv
/*
 * DRAM command generator: root-first path reads, leaf-first write-back,
 * linear sweep over the whole tree during init
 */
`default_nettype none

module pathAddrGen #(
	parameter int ORAML = oramPkg::ORAML,
	parameter int ORAMZ = oramPkg::ORAMZ
) (
	input wire Clock,
	input wire rstN,
	input wire pathStart,
	input wire [ORAML-1:0] pathLeaf,
	input wire pathWrite,
	input wire initMode,
	output logic pathDone,
	output oramPkg::dramCmdT DRAMCommand,
	output logic DRAMCommandValid,
	input wire DRAMCommandReady
);

	localparam int NumSlots = ((2 << ORAML) - 1) * ORAMZ;
	localparam int PathSlots = (ORAML + 1) * ORAMZ;
	localparam int CntW = $clog2(NumSlots + 1);

	logic active;
	logic writeMode;
	logic linMode;
	logic [ORAML-1:0] leaf;
	// Slot index within the walk
	logic [CntW-1:0] cnt;
	logic [CntW-1:0] lastCnt;
	int unsigned level;
	logic cmdFire;

	assign lastCnt = linMode ? CntW'(NumSlots - 1) : CntW'(PathSlots - 1);
	assign DRAMCommandValid = active;
	assign cmdFire = DRAMCommandValid && DRAMCommandReady;

	// Write-back walks levels bottom up, slot 0 first in each bucket
	always_comb begin
		level = cnt / ORAMZ;
		if (writeMode) level = ORAML - level;
		DRAMCommand.write = writeMode;
		if (linMode) begin
			DRAMCommand.addr = oramPkg::ddrAddrT'(cnt);
		end else begin
			DRAMCommand.addr = oramPkg::ddrAddrT'(oramPkg::pathSlotAddr(leaf, level,
				cnt % ORAMZ, ORAML, ORAMZ));
		end
	end

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			active <= 1'b0;
			pathDone <= 1'b0;
			writeMode <= 1'b0;
			linMode <= 1'b0;
			cnt <= '0;
		end else begin
			pathDone <= 1'b0;
			if (pathStart) begin
				active <= 1'b1;
				writeMode <= pathWrite;
				linMode <= initMode;
				cnt <= '0;
			end else if (cmdFire) begin
				if (cnt == lastCnt) begin
					active <= 1'b0;
					pathDone <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (pathStart) leaf <= pathLeaf;
	end

	// Tree holds NumSlots slots, the address field is wider
	assert property (@(posedge Clock) disable iff (!rstN)
		DRAMCommandValid |-> DRAMCommand.addr < NumSlots);

endmodule

`default_nettype wire

// File: verilog/pathOramBackend.sv
/*
 * Path ORAM backend top: control FSM, path address generator,
 * stash and slot cipher between the frontend and DRAM
 */
`default_nettype none

module pathOramBackend #(
	parameter int ORAML = oramPkg::ORAML,
	parameter int ORAMZ = oramPkg::ORAMZ,
	parameter int ORAMU = oramPkg::ORAMU,
	parameter int FEDWidth = oramPkg::FEDWidth,
	parameter int ORAMC = oramPkg::ORAMC,
	parameter logic [31:0] CipherKey = 32'h5a17c3e9
) (
	input wire Clock,
	input wire rstN,

	// Frontend
	input wire oramPkg::bkReqT Command,
	input wire CommandValid,
	output logic CommandReady,
	output logic [FEDWidth-1:0] LoadData,
	output logic LoadValid,
	input wire LoadReady,
	input wire [FEDWidth-1:0] StoreData,
	input wire StoreValid,
	output logic StoreReady,

	// DRAM
	output oramPkg::dramCmdT DRAMCommand,
	output logic DRAMCommandValid,
	input wire DRAMCommandReady,
	input wire oramPkg::dramWordT DRAMReadData,
	input wire DRAMReadDataValid,
	output logic DRAMReadDataReady,
	output oramPkg::dramWordT DRAMWriteData,
	output logic DRAMWriteDataValid,
	input wire DRAMWriteDataReady
);

	// --------------------
	// Control to address generator
	logic pathStart;
	logic pathWrite;
	logic pathDone;
	logic [ORAML-1:0] pathLeaf;
	logic initDone;

	// Control to stash
	oramPkg::bkReqT request;
	logic serveGo;
	logic remapGo;
	logic storeFire;
	logic absorbDone;
	logic evictDone;
	logic [ORAML-1:0] evictLeaf;

	// Stash to and from the cipher
	oramPkg::slotT absorbSlot;
	logic absorbValid;
	oramPkg::ddrAddrT absorbAddr;
	oramPkg::slotT evictSlot;
	logic evictValid;
	logic evictReady;
	oramPkg::ddrAddrT evictAddr;

	backendControl #(.ORAML(ORAML)) control (
		.Clock(Clock), .rstN(rstN),
		.Command(Command), .CommandValid(CommandValid), .CommandReady(CommandReady),
		.StoreValid(StoreValid), .StoreReady(StoreReady),
		.LoadReady(LoadReady), .LoadValid(LoadValid),
		.pathStart(pathStart), .pathLeaf(pathLeaf), .pathWrite(pathWrite),
		.pathDone(pathDone),
		.absorbDone(absorbDone), .evictDone(evictDone), .serveGo(serveGo),
		.remapGo(remapGo), .storeFire(storeFire), .evictLeaf(evictLeaf),
		.request(request), .initDone(initDone)
	);

	pathAddrGen #(.ORAML(ORAML), .ORAMZ(ORAMZ)) addrGen (
		.Clock(Clock), .rstN(rstN),
		.pathStart(pathStart), .pathLeaf(pathLeaf), .pathWrite(pathWrite),
		.initMode(!initDone), .pathDone(pathDone),
		.DRAMCommand(DRAMCommand), .DRAMCommandValid(DRAMCommandValid),
		.DRAMCommandReady(DRAMCommandReady)
	);

	stash #(
		.ORAML(ORAML), .ORAMZ(ORAMZ), .ORAMU(ORAMU), .FEDWidth(FEDWidth), .ORAMC(ORAMC)
	) blockStash (
		.Clock(Clock), .rstN(rstN),
		.absorbSlot(absorbSlot), .absorbValid(absorbValid), .absorbDone(absorbDone),
		.absorbAddr(absorbAddr),
		.serveGo(serveGo), .request(request), .StoreData(StoreData),
		.storeFire(storeFire), .LoadData(LoadData), .remapGo(remapGo),
		.evictLeaf(evictLeaf), .evictSlot(evictSlot), .evictValid(evictValid),
		.evictReady(evictReady), .evictAddr(evictAddr), .evictDone(evictDone),
		.initDone(initDone)
	);

	slotCipher #(.CipherKey(CipherKey)) cipher (
		.Clock(Clock), .rstN(rstN),
		.encIn(evictSlot), .encInValid(evictValid), .encInReady(evictReady),
		.encAddr(evictAddr),
		.encOut(DRAMWriteData), .encOutValid(DRAMWriteDataValid),
		.encOutReady(DRAMWriteDataReady),
		.decIn(DRAMReadData), .decInValid(DRAMReadDataValid),
		.decInReady(DRAMReadDataReady), .decAddr(absorbAddr),
		.decOut(absorbSlot), .decOutValid(absorbValid)
	);

endmodule

`default_nettype wire

// File: verilog/slotCipher.sv
/*
 * Slot cipher: one registered stage per direction, keyed pad over
 * slot address and a per-write seed
 */
`default_nettype none

module slotCipher #(
	parameter logic [31:0] CipherKey = 32'h5a17c3e9
) (
	input wire Clock,
	input wire rstN,
	// Stash to DRAM
	input wire oramPkg::slotT encIn,
	input wire encInValid,
	output logic encInReady,
	input wire oramPkg::ddrAddrT encAddr,
	output oramPkg::dramWordT encOut,
	output logic encOutValid,
	input wire encOutReady,
	// DRAM to stash
	input wire oramPkg::dramWordT decIn,
	input wire decInValid,
	output logic decInReady,
	input wire oramPkg::ddrAddrT decAddr,
	output oramPkg::slotT decOut,
	output logic decOutValid
);

	localparam int SlotW = $bits(oramPkg::slotT);
	localparam int SeedW = oramPkg::SeedWidth;

	logic [SeedW-1:0] seed;
	oramPkg::dramWordT decWord;
	logic encFire;

	function automatic logic [SlotW-1:0] rotl(input logic [SlotW-1:0] v, input int n);
		return (v << n) | (v >> (SlotW - n));
	endfunction

	// --------------------
	// Pad: {seed,addr} repeated, xor key; then two rounds
	// Rotate by 7 then 13, xor key, add key rotated by 21
	function automatic logic [SlotW-1:0] slotPad(input oramPkg::ddrAddrT addr,
			input logic [SeedW-1:0] s);
		logic [SlotW-1:0] key;
		logic [SlotW-1:0] v;
		key = SlotW'({CipherKey, CipherKey});
		v = SlotW'({4{s, addr}}) ^ key;
		v = rotl(v, 7) ^ key;
		v = v + rotl(key, 21);
		v = rotl(v, 13) ^ key;
		v = v + rotl(key, 21);
		return v;
	endfunction

	assign encInReady = !encOutValid || encOutReady;
	assign encFire = encInValid && encInReady;

	// Stash takes a decrypted slot every cycle
	assign decInReady = 1'b1;
	// Address arrives with the registered word
	assign decOut = oramPkg::slotT'(decWord.cipher ^ slotPad(decAddr, decWord.seed));

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			encOutValid <= 1'b0;
			decOutValid <= 1'b0;
			seed <= '0;
		end else begin
			if (encFire) begin
				encOutValid <= 1'b1;
				// Fresh seed for every write word
				seed <= seed + 1'b1;
			end else if (encOutReady) begin
				encOutValid <= 1'b0;
			end
			decOutValid <= decInValid && decInReady;
		end
	end

	always_ff @(posedge Clock) begin
		if (encFire) encOut <= '{seed: seed, cipher: encIn ^ slotPad(encAddr, seed)};
		if (decInValid) decWord <= decIn;
	end

endmodule

`default_nettype wire

// File: verilog/stash.sv
/*
 * Stash: absorbs the read path, serves load and store, remaps,
 * and picks the oldest eligible block for each write-back slot
 */
`default_nettype none

module stash #(
	parameter int ORAML = oramPkg::ORAML,
	parameter int ORAMZ = oramPkg::ORAMZ,
	parameter int ORAMU = oramPkg::ORAMU,
	parameter int FEDWidth = oramPkg::FEDWidth,
	parameter int ORAMC = oramPkg::ORAMC
) (
	input wire Clock,
	input wire rstN,
	// Decrypted path slots
	input wire oramPkg::slotT absorbSlot,
	input wire absorbValid,
	output logic absorbDone,
	output oramPkg::ddrAddrT absorbAddr,
	// Serve and remap
	input wire serveGo,
	input wire oramPkg::bkReqT request,
	input wire [FEDWidth-1:0] StoreData,
	input wire storeFire,
	output logic [FEDWidth-1:0] LoadData,
	input wire remapGo,
	// Write-back slots
	input wire [ORAML-1:0] evictLeaf,
	output oramPkg::slotT evictSlot,
	output logic evictValid,
	input wire evictReady,
	output oramPkg::ddrAddrT evictAddr,
	output logic evictDone,
	input wire initDone
);

	localparam int NumSlots = ((2 << ORAML) - 1) * ORAMZ;
	localparam int PathSlots = (ORAML + 1) * ORAMZ;
	localparam int CntW = $clog2(NumSlots + 1);
	localparam int IdxW = $clog2(ORAMC);
	localparam int AgeW = 8;

	oramPkg::slotT entry [ORAMC];
	logic [AgeW-1:0] age [ORAMC];
	logic [ORAMC-1:0] used;
	logic [IdxW-1:0] servIdx;
	logic [ORAMU-1:0] reqAddr;

	logic matchHit, freeHit, pickHit;
	logic [IdxW-1:0] matchIdx, freeIdx, pickIdx;
	logic [AgeW-1:0] pickAge;
	logic insert;
	oramPkg::slotT insertSlot;

	logic evicting;
	logic evictFire;
	logic [CntW-1:0] evictCnt, lastEvict;
	logic [CntW-1:0] absorbCnt;
	int unsigned evictShift;

	assign reqAddr = request.pAddr;
	assign LoadData = entry[servIdx].data;

	// --------------------
	// Lookup and free slot search
	always_comb begin
		matchHit = 1'b0;
		matchIdx = '0;
		freeHit = 1'b0;
		freeIdx = '0;
		for (int i = 0; i < ORAMC; i++) begin
			if (used[i] && entry[i].pAddr == reqAddr && !matchHit) begin
				matchHit = 1'b1;
				matchIdx = IdxW'(i);
			end
			if (!used[i] && !freeHit) begin
				freeHit = 1'b1;
				freeIdx = IdxW'(i);
			end
		end
	end

	// Real path slots enter, dummies are dropped
	// A missing block is created with zero data on serve
	assign insert = (absorbValid && absorbSlot.valid) || (serveGo && !matchHit);
	always_comb begin
		if (absorbValid) insertSlot = absorbSlot;
		else insertSlot = '{valid: 1'b1, pAddr: reqAddr, leaf: request.currentLeaf, data: '0};
	end

	// --------------------
	// Eviction pick, leaf level first
	assign evictShift = evictCnt / ORAMZ;
	always_comb begin
		pickHit = 1'b0;
		pickIdx = '0;
		pickAge = '0;
		for (int i = 0; i < ORAMC; i++) begin
			// Leaf prefixes agree down to this level
			if (used[i] && (entry[i].leaf >> evictShift) == (evictLeaf >> evictShift)
					&& (!pickHit || age[i] > pickAge)) begin
				pickHit = 1'b1;
				pickIdx = IdxW'(i);
				pickAge = age[i];
			end
		end
	end

	// Init writes dummies over the whole tree
	assign evictSlot = (initDone && pickHit) ? entry[pickIdx] : '0;
	assign evictValid = evicting;
	assign evictFire = evictValid && evictReady;
	assign lastEvict = initDone ? CntW'(PathSlots - 1) : CntW'(NumSlots - 1);
	assign evictAddr = initDone ? oramPkg::ddrAddrT'(oramPkg::pathSlotAddr(evictLeaf,
		ORAML - evictShift, evictCnt % ORAMZ, ORAML, ORAMZ)) : oramPkg::ddrAddrT'(evictCnt);
	// Root-first order of the read path
	assign absorbAddr = oramPkg::ddrAddrT'(oramPkg::pathSlotAddr(request.currentLeaf,
		absorbCnt / ORAMZ, absorbCnt % ORAMZ, ORAML, ORAMZ));

	always_ff @(posedge Clock or negedge rstN) begin
		if (!rstN) begin
			used <= '0;
			evicting <= 1'b1;
			evictCnt <= '0;
			absorbCnt <= '0;
			absorbDone <= 1'b0;
			evictDone <= 1'b0;
		end else begin
			absorbDone <= 1'b0;
			evictDone <= 1'b0;
			if (insert) used[freeIdx] <= 1'b1;
			if (absorbValid) begin
				if (absorbCnt == CntW'(PathSlots - 1)) begin
					absorbCnt <= '0;
					absorbDone <= 1'b1;
				end else begin
					absorbCnt <= absorbCnt + 1'b1;
				end
			end
			if (remapGo) begin
				evicting <= 1'b1;
				evictCnt <= '0;
			end else if (evictFire) begin
				if (initDone && pickHit) used[pickIdx] <= 1'b0;
				if (evictCnt == lastEvict) begin
					evicting <= 1'b0;
					evictDone <= 1'b1;
				end else begin
					evictCnt <= evictCnt + 1'b1;
				end
			end
		end
	end

	// Entry payload and ages, newest entry has age 0
	always_ff @(posedge Clock) begin
		if (insert) begin
			for (int i = 0; i < ORAMC; i++) begin
				if (age[i] != '1) age[i] <= age[i] + 1'b1;
			end
			entry[freeIdx] <= insertSlot;
			age[freeIdx] <= '0;
		end
		if (serveGo) servIdx <= matchHit ? matchIdx : freeIdx;
		if (storeFire) entry[servIdx].data <= StoreData;
		if (remapGo) entry[servIdx].leaf <= request.remappedLeaf;
	end

	// Occupancy stays within ORAMC
	assert property (@(posedge Clock) disable iff (!rstN) insert |-> freeHit);

endmodule

`default_nettype wire
